//--- include/wb_config.svh
`ifndef WB_CONFIG_SVH
`define WB_CONFIG_SVH

// memory stage to write-back bus, fields listed in ws_latch
`define MS_TO_WS_BUS_WD 120

// cp0 register numbers, select 0 for all of them
`define CP0_BADVADDR    5'd8
`define CP0_COUNT       5'd9
`define CP0_COMPARE     5'd11
`define CP0_STATUS      5'd12
`define CP0_CAUSE       5'd13
`define CP0_EPC         5'd14
`define CP0_SEL_DEFAULT 3'd0

// general exception entry
`define EXC_VECTOR      32'hbfc00380

`endif

//--- source/wb_pkg.sv
package wb_pkg;

    // exception codes as recorded in Cause.ExcCode
    typedef enum logic [4:0] {
        exc_int  = 5'd0,
        exc_adel = 5'd4,
        exc_ades = 5'd5,
        exc_sys  = 5'd8,
        exc_bp   = 5'd9,
        exc_ri   = 5'd10,
        exc_ov   = 5'd12
    } exc_code_e;

    typedef struct packed {
        logic [15:0] rsvd_hi;   // reads as zero
        logic [7:0]  im;        // interrupt mask
        logic [5:0]  rsvd_lo;
        logic        exl;       // exception level
        logic        ie;        // global interrupt enable
    } status_t;

    typedef struct packed {
        logic        bd;        // last exception was in a delay slot
        logic        ti;        // timer interrupt
        logic [13:0] rsvd_hi;
        logic [7:0]  ip;        // pending interrupts, 1:0 are software
        logic        rsvd_mid;
        exc_code_e   exc_code;
        logic [1:0]  rsvd_lo;
    } cause_t;

    // mtc0 data word, seen as Status or Cause depending on cp0_rd
    typedef union packed {
        status_t     status;
        cause_t      cause;
        logic [31:0] raw;
    } cp0_wdata_u;

endpackage

//--- source/ws_latch.sv
`timescale 1ns/1ps
`include "wb_config.svh"

module ws_latch (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         ms_to_ws_valid,
    input  logic [`MS_TO_WS_BUS_WD-1:0]  ms_to_ws_bus,
    input  logic                         flush,
    output logic                         ws_allowin,
    output logic                         ws_valid,
    output logic                         ex,
    output wb_pkg::exc_code_e            exc_code,
    output logic                         bd,
    output logic                         eret,
    output logic                         mtc0,
    output logic                         mfc0,
    output logic [4:0]                   cp0_rd,
    output logic [2:0]                   cp0_sel,
    output logic                         gr_we,
    output logic [4:0]                   dest,
    output logic [31:0]                  result,
    output logic [31:0]                  badvaddr,
    output logic [31:0]                  pc
);
    import wb_pkg::*;

    logic [`MS_TO_WS_BUS_WD-1:0] ms_to_ws_bus_r;
    logic [4:0]                  exc_code_raw;

    assign ws_allowin = 1'b1;                       // write-back never stalls

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (flush) begin
            ws_valid <= 1'b0;                       // drop the item offered with the flush
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            ms_to_ws_bus_r <= ms_to_ws_bus;
        end
    end

    assign {ex,              // 119
            exc_code_raw,    // 118:114
            bd,              // 113
            eret,            // 112
            mtc0,            // 111
            mfc0,            // 110
            cp0_rd,          // 109:105
            cp0_sel,         // 104:102
            gr_we,           // 101
            dest,            // 100:96
            result,          // 95:64
            badvaddr,        // 63:32
            pc               // 31:0
           } = ms_to_ws_bus_r;

    assign exc_code = exc_code_e'(exc_code_raw);

endmodule

//--- source/cp0_regs.sv
`timescale 1ns/1ps
`include "wb_config.svh"

module cp0_regs (
    input  logic              clk,
    input  logic              reset,
    input  logic              ws_valid,
    input  logic              ex,
    input  wb_pkg::exc_code_e exc_code,
    input  logic              bd,
    input  logic              eret,
    input  logic              mtc0,
    input  logic [4:0]        cp0_rd,
    input  logic [2:0]        cp0_sel,
    input  logic [31:0]       result,
    input  logic [31:0]       badvaddr,
    input  logic [31:0]       pc,
    input  logic [5:0]        ext_int,
    input  logic              timer_int,
    output logic [31:0]       rdata,
    output logic              rhit,
    output logic [31:0]       epc,
    output logic              int_pending
);
    import wb_pkg::*;

    status_t     status_r;
    cause_t      cause_r;
    cause_t      cause_rd;      // cause as software sees it
    logic [31:0] epc_r;
    logic [31:0] badvaddr_r;
    cp0_wdata_u  wdata;

    logic exc_commit;
    logic eret_commit;
    logic mtc0_commit;
    logic sel0;
    logic wr_status;
    logic wr_cause;
    logic wr_epc;

    assign exc_commit  = ws_valid && ex;
    assign eret_commit = ws_valid && eret && !ex;
    assign mtc0_commit = ws_valid && mtc0 && !ex;
    assign sel0        = (cp0_sel == `CP0_SEL_DEFAULT);

    assign wr_status = mtc0_commit && sel0 && (cp0_rd == `CP0_STATUS);
    assign wr_cause  = mtc0_commit && sel0 && (cp0_rd == `CP0_CAUSE);
    assign wr_epc    = mtc0_commit && sel0 && (cp0_rd == `CP0_EPC);

    assign wdata.raw = result;

    always_ff @(posedge clk) begin
        if (reset) begin
            status_r <= '0;
        end else if (exc_commit) begin
            status_r.exl <= 1'b1;
        end else if (eret_commit) begin
            status_r.exl <= 1'b0;
        end else if (wr_status) begin
            status_r.im  <= wdata.status.im;        // only im, exl and ie are writable
            status_r.exl <= wdata.status.exl;
            status_r.ie  <= wdata.status.ie;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause_r <= '0;
        end else begin
            cause_r.ip[7:2] <= ext_int;             // hardware lines sampled every edge
            if (exc_commit) begin
                cause_r.bd       <= bd;
                cause_r.exc_code <= exc_code;
            end else if (wr_cause) begin
                cause_r.ip[1:0] <= wdata.cause.ip[1:0]; // software interrupts
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exc_commit && !status_r.exl) begin
            epc_r <= bd ? pc - 32'd4 : pc;          // nested exception keeps old epc
        end else if (wr_epc) begin
            epc_r <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (exc_commit && (exc_code == exc_adel || exc_code == exc_ades)) begin
            badvaddr_r <= badvaddr;
        end
    end

    // timer interrupt shows as TI and shares ip bit 7 with ext_int[5]
    always_comb begin
        cause_rd       = cause_r;
        cause_rd.ti    = timer_int;
        cause_rd.ip[7] = cause_r.ip[7] | timer_int;
    end

    always_comb begin
        rhit  = sel0;
        rdata = '0;
        case (cp0_rd)
            `CP0_STATUS:   rdata = status_r;
            `CP0_CAUSE:    rdata = cause_rd;
            `CP0_EPC:      rdata = epc_r;
            `CP0_BADVADDR: rdata = badvaddr_r;
            default:       rhit  = 1'b0;
        endcase
        if (!sel0) begin
            rdata = '0;
        end
    end

    assign epc         = epc_r;
    assign int_pending = status_r.ie && !status_r.exl && |(cause_rd.ip & status_r.im);

endmodule

//--- source/cp0_timer.sv
`timescale 1ns/1ps
`include "wb_config.svh"

module cp0_timer (
    input  logic        clk,
    input  logic        reset,
    input  logic        ws_valid,
    input  logic        mtc0,
    input  logic        ex,
    input  logic [4:0]  cp0_rd,
    input  logic [2:0]  cp0_sel,
    input  logic [31:0] result,
    output logic [31:0] rdata,
    output logic        rhit,
    output logic        timer_int
);

    logic [31:0] count;
    logic [31:0] compare;
    logic        tick;          // count advances every second edge
    logic        sel0;
    logic        wr_count;
    logic        wr_compare;

    assign sel0       = (cp0_sel == `CP0_SEL_DEFAULT);
    assign wr_count   = ws_valid && mtc0 && !ex && sel0 && (cp0_rd == `CP0_COUNT);
    assign wr_compare = ws_valid && mtc0 && !ex && sel0 && (cp0_rd == `CP0_COMPARE);

    always_ff @(posedge clk) begin
        if (reset) begin
            tick  <= 1'b0;
            count <= '0;
        end else begin
            tick <= ~tick;
            if (wr_count) begin
                count <= result;
            end else if (tick) begin
                count <= count + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compare   <= '0;
            timer_int <= 1'b0;
        end else if (wr_compare) begin
            compare   <= result;
            timer_int <= 1'b0;                      // writing compare acknowledges
        end else if (count == compare) begin
            timer_int <= 1'b1;
        end
    end

    assign rhit  = sel0 && (cp0_rd == `CP0_COUNT || cp0_rd == `CP0_COMPARE);
    assign rdata = !rhit                  ? 32'd0 :
                   (cp0_rd == `CP0_COUNT) ? count : compare;

endmodule

//--- source/wb_commit.sv
`timescale 1ns/1ps
`include "wb_config.svh"

module wb_commit (
    input  logic        ws_valid,
    input  logic        ex,
    input  logic        eret,
    input  logic        mfc0,
    input  logic        gr_we,
    input  logic [4:0]  dest,
    input  logic [31:0] result,
    input  logic [31:0] regs_rdata,
    input  logic        regs_rhit,
    input  logic [31:0] timer_rdata,
    input  logic        timer_rhit,
    input  logic [31:0] epc,
    output logic        rf_we,
    output logic [4:0]  rf_waddr,
    output logic [31:0] rf_wdata,
    output logic [4:0]  wb_dest,
    output logic [31:0] wb_result,
    output logic        flush,
    output logic [31:0] flush_pc
);

    logic [31:0] cp0_rdata;
    logic [31:0] final_result;

    // unimplemented cp0 registers read as zero
    assign cp0_rdata = regs_rhit  ? regs_rdata  :
                       timer_rhit ? timer_rdata : 32'd0;

    assign final_result = mfc0 ? cp0_rdata : result;

    assign flush    = ws_valid && (ex || eret);
    assign flush_pc = (eret && !ex) ? epc : `EXC_VECTOR;  // exception wins over eret

    assign rf_we    = ws_valid && gr_we && !ex && !eret; // never writes on a flush
    assign rf_waddr = dest;
    assign rf_wdata = final_result;

    assign wb_dest   = dest & {5{ws_valid}};          // empty stage forwards nothing
    assign wb_result = final_result;

endmodule

//--- source/wb_stage.sv
`timescale 1ns/1ps
`include "wb_config.svh"

module wb_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        ms_to_ws_valid,
    input  logic [`MS_TO_WS_BUS_WD-1:0] ms_to_ws_bus,
    input  logic [5:0]                  ext_int,
    output logic                        ws_allowin,
    output logic                        rf_we,
    output logic [4:0]                  rf_waddr,
    output logic [31:0]                 rf_wdata,
    output logic [4:0]                  wb_dest,
    output logic [31:0]                 wb_result,
    output logic                        flush,
    output logic [31:0]                 flush_pc,
    output logic                        int_pending
);
    import wb_pkg::*;

    logic        ws_valid;
    logic        ex;
    exc_code_e   exc_code;
    logic        bd;
    logic        eret;
    logic        mtc0;
    logic        mfc0;
    logic [4:0]  cp0_rd;
    logic [2:0]  cp0_sel;
    logic        gr_we;
    logic [4:0]  dest;
    logic [31:0] result;
    logic [31:0] badvaddr;
    logic [31:0] pc;

    logic [31:0] regs_rdata;
    logic        regs_rhit;
    logic [31:0] timer_rdata;
    logic        timer_rhit;
    logic        timer_int;
    logic [31:0] epc;

    ws_latch ws_latch_inst (
        .clk            (clk),
        .reset          (reset),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .flush          (flush),
        .ws_allowin     (ws_allowin),
        .ws_valid       (ws_valid),
        .ex             (ex),
        .exc_code       (exc_code),
        .bd             (bd),
        .eret           (eret),
        .mtc0           (mtc0),
        .mfc0           (mfc0),
        .cp0_rd         (cp0_rd),
        .cp0_sel        (cp0_sel),
        .gr_we          (gr_we),
        .dest           (dest),
        .result         (result),
        .badvaddr       (badvaddr),
        .pc             (pc)
    );

    cp0_regs cp0_regs_inst (
        .clk         (clk),
        .reset       (reset),
        .ws_valid    (ws_valid),
        .ex          (ex),
        .exc_code    (exc_code),
        .bd          (bd),
        .eret        (eret),
        .mtc0        (mtc0),
        .cp0_rd      (cp0_rd),
        .cp0_sel     (cp0_sel),
        .result      (result),
        .badvaddr    (badvaddr),
        .pc          (pc),
        .ext_int     (ext_int),
        .timer_int   (timer_int),
        .rdata       (regs_rdata),
        .rhit        (regs_rhit),
        .epc         (epc),
        .int_pending (int_pending)
    );

    cp0_timer cp0_timer_inst (
        .clk       (clk),
        .reset     (reset),
        .ws_valid  (ws_valid),
        .mtc0      (mtc0),
        .ex        (ex),
        .cp0_rd    (cp0_rd),
        .cp0_sel   (cp0_sel),
        .result    (result),
        .rdata     (timer_rdata),
        .rhit      (timer_rhit),
        .timer_int (timer_int)
    );

    wb_commit wb_commit_inst (
        .ws_valid    (ws_valid),
        .ex          (ex),
        .eret        (eret),
        .mfc0        (mfc0),
        .gr_we       (gr_we),
        .dest        (dest),
        .result      (result),
        .regs_rdata  (regs_rdata),
        .regs_rhit   (regs_rhit),
        .timer_rdata (timer_rdata),
        .timer_rhit  (timer_rhit),
        .epc         (epc),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_wdata    (rf_wdata),
        .wb_dest     (wb_dest),
        .wb_result   (wb_result),
        .flush       (flush),
        .flush_pc    (flush_pc)
    );

endmodule

//--- sim/wb_stage_chk.sv
`timescale 1ns/1ps

module wb_stage_chk (
    input logic clk,
    input logic reset,
    input logic ws_allowin,
    input logic rf_we,
    input logic flush,
    input logic ws_valid,
    input logic int_pending,
    input logic exl
);

    int assert_fails = 0;       // failed assertions so far

    // write-back never applies back-pressure
    allowin_high: assert property (@(posedge clk) disable iff (reset) ws_allowin)
        else begin
            $error("ws_allowin went low");
            assert_fails++;
        end

    no_write_on_flush: assert property (@(posedge clk) disable iff (reset) rf_we |-> !flush)
        else begin
            $error("register write during a flush");
            assert_fails++;
        end

    flush_needs_valid: assert property (@(posedge clk) disable iff (reset) flush |-> ws_valid)
        else begin
            $error("flush from an empty stage");
            assert_fails++;
        end

    no_int_at_exl: assert property (@(posedge clk) disable iff (reset) exl |-> !int_pending)
        else begin
            $error("interrupt pending while exl is set");
            assert_fails++;
        end

endmodule

//--- sim/wb_stage_tb.sv
`timescale 1ns/1ps
`include "wb_config.svh"

module wb_stage_tb;
    import wb_pkg::*;

    typedef struct packed {
        logic        rf_we;
        logic [4:0]  rf_waddr;
        logic [31:0] rf_wdata;
        logic [4:0]  wb_dest;
        logic        flush;
        logic [31:0] flush_pc;
    } expect_t;

    logic                        clk;
    logic                        reset;
    logic                        ms_to_ws_valid;
    logic [`MS_TO_WS_BUS_WD-1:0] ms_to_ws_bus;
    logic [5:0]                  ext_int;
    logic                        ws_allowin;
    logic                        rf_we;
    logic [4:0]                  rf_waddr;
    logic [31:0]                 rf_wdata;
    logic [4:0]                  wb_dest;
    logic [31:0]                 wb_result;
    logic                        flush;
    logic [31:0]                 flush_pc;
    logic                        int_pending;

    integer      seed;
    int          items_sent;
    int          cycles;
    logic [31:0] cur_pc;
    logic [31:0] rnd;

    // item in write-back as the model sees it, plus cp0 model state
    logic                        wb_valid_m;
    logic [`MS_TO_WS_BUS_WD-1:0] wb_bus_m;
    logic [7:0]  m_im;
    logic        m_exl;
    logic        m_ie;
    logic        m_bd;
    logic [4:0]  m_code;
    logic [1:0]  m_ip_sw;
    logic [5:0]  m_ip_hw;
    logic        m_ti;
    logic        m_tick;
    logic [31:0] m_epc;
    logic [31:0] m_badvaddr;
    logic [31:0] m_count;
    logic [31:0] m_compare;

    wb_stage wb_stage_inst (
        .clk            (clk),
        .reset          (reset),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .ext_int        (ext_int),
        .ws_allowin     (ws_allowin),
        .rf_we          (rf_we),
        .rf_waddr       (rf_waddr),
        .rf_wdata       (rf_wdata),
        .wb_dest        (wb_dest),
        .wb_result      (wb_result),
        .flush          (flush),
        .flush_pc       (flush_pc),
        .int_pending    (int_pending)
    );

    bind wb_stage wb_stage_chk wb_stage_chk_inst (
        .clk         (clk),
        .reset       (reset),
        .ws_allowin  (ws_allowin),
        .rf_we       (rf_we),
        .flush       (flush),
        .ws_valid    (ws_valid),
        .int_pending (int_pending),
        .exl         (cp0_regs_inst.status_r.exl)
    );

    always #5 clk = ~clk;

    function automatic logic [7:0] ip_now();
        return {m_ip_hw[5] | m_ti, m_ip_hw[4:0], m_ip_sw};  // ti shares ip7
    endfunction

    function automatic logic [31:0] cp0_read(input logic [4:0] rd, input logic [2:0] sel);
        if (sel != 3'd0) begin
            return 32'd0;
        end
        case (rd)
            `CP0_STATUS:   return {16'd0, m_im, 6'd0, m_exl, m_ie};
            `CP0_CAUSE:    return {m_bd, m_ti, 14'd0, ip_now(), 1'b0, m_code, 2'd0};
            `CP0_EPC:      return m_epc;
            `CP0_BADVADDR: return m_badvaddr;
            `CP0_COUNT:    return m_count;
            `CP0_COMPARE:  return m_compare;
            default:       return 32'd0;
        endcase
    endfunction

    function automatic expect_t ref_commit(input logic valid, input logic [119:0] bus);
        expect_t e;
        e.rf_wdata = bus[110] ? cp0_read(bus[109:105], bus[104:102]) : bus[95:64];
        e.rf_we    = valid && bus[101] && !bus[119] && !bus[112];
        e.rf_waddr = bus[100:96];
        e.wb_dest  = valid ? bus[100:96] : 5'd0;
        e.flush    = valid && (bus[119] || bus[112]);
        e.flush_pc = bus[119] ? `EXC_VECTOR : m_epc;
        return e;
    endfunction

    function automatic logic int_expected();
        return m_ie && !m_exl && |(ip_now() & m_im);
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, want);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin : compare_outputs
        expect_t e;
        if (!reset) begin
            e = ref_commit(wb_valid_m, wb_bus_m);
            check("rf_we", rf_we, e.rf_we);
            check("wb_dest", wb_dest, e.wb_dest);
            check("flush", flush, e.flush);
            check("int_pending", int_pending, int_expected());
            if (e.rf_we) begin
                check("rf_waddr", rf_waddr, e.rf_waddr);
                check("rf_wdata", rf_wdata, e.rf_wdata);
            end
            if (wb_valid_m) begin
                check("wb_result", wb_result, e.rf_wdata);
            end
            if (e.flush) begin
                check("flush_pc", flush_pc, e.flush_pc);
            end
        end
    end

    always @(wb_stage_inst.wb_stage_chk_inst.assert_fails) begin
        if (wb_stage_inst.wb_stage_chk_inst.assert_fails != 0) begin
            $display("An assertion in the checker failed");
            $display("TEST FAILED");
            $fatal(1, "assertion failed");
        end
    end

    always @(posedge clk) begin : cp0_model
        logic        do_ex;
        logic        do_eret;
        logic        do_mtc0;
        logic [4:0]  rd;
        logic [31:0] val;
        do_ex   = wb_valid_m && wb_bus_m[119];
        do_eret = wb_valid_m && !wb_bus_m[119] && wb_bus_m[112];
        do_mtc0 = wb_valid_m && !wb_bus_m[119] && wb_bus_m[111] && wb_bus_m[104:102] == 3'd0;
        rd      = wb_bus_m[109:105];
        val     = wb_bus_m[95:64];
        if (reset) begin
            wb_valid_m <= 1'b0;
            {m_im, m_exl, m_ie, m_bd, m_code} <= '0;
            {m_ip_sw, m_ip_hw, m_ti, m_tick} <= '0;
            {m_epc, m_badvaddr, m_count, m_compare} <= '0;
        end else begin
            wb_valid_m <= ms_to_ws_valid && !(do_ex || do_eret);  // flush drops the new item
            if (ms_to_ws_valid) begin
                wb_bus_m <= ms_to_ws_bus;
            end
            m_ip_hw <= ext_int;
            m_tick  <= !m_tick;
            if (do_mtc0 && rd == `CP0_COUNT) begin
                m_count <= val;
            end else if (m_tick) begin
                m_count <= m_count + 32'd1;         // every second edge
            end
            if (do_mtc0 && rd == `CP0_COMPARE) begin
                m_compare <= val;
                m_ti      <= 1'b0;
            end else if (m_count == m_compare) begin
                m_ti <= 1'b1;
            end
            if (do_ex) begin
                m_exl  <= 1'b1;
                m_bd   <= wb_bus_m[113];
                m_code <= wb_bus_m[118:114];
                if (!m_exl) begin
                    m_epc <= wb_bus_m[113] ? wb_bus_m[31:0] - 32'd4 : wb_bus_m[31:0];
                end
                if (wb_bus_m[118:114] == exc_adel || wb_bus_m[118:114] == exc_ades) begin
                    m_badvaddr <= wb_bus_m[63:32];
                end
            end else if (do_eret) begin
                m_exl <= 1'b0;
            end else if (do_mtc0) begin
                case (rd)
                    `CP0_STATUS: {m_im, m_exl, m_ie} <= {val[15:8], val[1], val[0]};
                    `CP0_CAUSE:  m_ip_sw <= val[9:8];
                    `CP0_EPC:    m_epc <= val;
                    default:     ;
                endcase
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > 2 * items_sent + 200) begin
            $display("Timeout: the run did not finish within %0d cycles", cycles);
            $display("TEST FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // drives one item and returns at the edge that takes it
    task automatic offer(input logic [119:0] bus);
        logic taken;
        ms_to_ws_valid <= 1'b1;
        ms_to_ws_bus   <= bus;
        items_sent = items_sent + 1;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = ws_allowin;
            @(posedge clk);
        end
    endtask

    task automatic idle(input int n);
        ms_to_ws_valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_int(input logic level);
        do begin
            @(negedge clk);
        end while (int_pending !== level);
        @(posedge clk);
    endtask

    task automatic send_alu(input logic gr_we, input logic [4:0] dest, input logic [31:0] value);
        cur_pc = cur_pc + 32'd4;
        offer({1'b0, 5'd0, 4'b0000, 5'd0, 3'd0, gr_we, dest, value, 32'd0, cur_pc});
    endtask

    task automatic send_mtc0(input logic [4:0] rd, input logic [31:0] value);
        cur_pc = cur_pc + 32'd4;
        offer({1'b0, 5'd0, 1'b0, 1'b0, 1'b1, 1'b0, rd, 3'd0, 1'b0, 5'd0, value, 32'd0, cur_pc});
    endtask

    task automatic send_mfc0(input logic [4:0] rd, input logic [2:0] sel, input logic [4:0] dest);
        cur_pc = cur_pc + 32'd4;
        offer({1'b0, 5'd0, 1'b0, 1'b0, 1'b0, 1'b1, rd, sel, 1'b1, dest, 64'd0, cur_pc});
    endtask

    task automatic send_exc(input logic [4:0] code, input logic bd, input logic [31:0] badvaddr);
        logic [31:0] value;
        value = $random(seed);
        cur_pc = cur_pc + 32'd4;
        offer({1'b1, code, bd, 3'b000, 5'd0, 3'd0, 1'b1, value[4:0], value, badvaddr, cur_pc});
    endtask

    task automatic send_eret();
        cur_pc = cur_pc + 32'd4;
        offer({1'b0, 5'd0, 1'b0, 1'b1, 1'b0, 1'b0, 5'd0, 3'd0, 1'b0, 5'd0, 64'd0, cur_pc});
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        ms_to_ws_valid = 1'b0;
        ms_to_ws_bus   = '0;
        ext_int        = '0;
        seed           = 32'h8e01;
        items_sent     = 0;
        cycles         = 0;
        cur_pc         = 32'hbfc0_0000;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        repeat (40) begin
            rnd = $random(seed);
            send_alu(rnd[0], rnd[5:1], $random(seed));
            if (rnd[6]) begin
                idle(1);                        // empty stage, wb_dest reads zero
            end
        end
        idle(2);

        send_mtc0(`CP0_STATUS, $random(seed));
        send_mfc0(`CP0_STATUS, 3'd0, 5'd1);
        send_mtc0(`CP0_CAUSE, $random(seed));
        send_mfc0(`CP0_CAUSE, 3'd0, 5'd2);
        send_mtc0(`CP0_EPC, $random(seed));
        send_mfc0(`CP0_EPC, 3'd0, 5'd3);
        send_mfc0(5'd7, 3'd0, 5'd4);            // not implemented
        send_mfc0(`CP0_STATUS, 3'd1, 5'd5);     // wrong select
        send_mtc0(`CP0_STATUS, 32'd0);
        idle(2);

        send_exc(exc_adel, 1'b0, $random(seed));
        send_alu(1'b1, 5'd7, 32'h1234_5678);    // offered with the flush
        idle(1);
        send_mfc0(`CP0_EPC, 3'd0, 5'd2);
        send_mfc0(`CP0_STATUS, 3'd0, 5'd3);
        send_mfc0(`CP0_CAUSE, 3'd0, 5'd4);
        send_mfc0(`CP0_BADVADDR, 3'd0, 5'd5);
        send_eret();
        idle(1);
        send_mfc0(`CP0_STATUS, 3'd0, 5'd6);
        send_exc(exc_sys, 1'b1, 32'd0);         // delay slot
        idle(1);
        send_mfc0(`CP0_EPC, 3'd0, 5'd2);
        send_mfc0(`CP0_CAUSE, 3'd0, 5'd4);
        send_eret();
        idle(2);

        send_mtc0(`CP0_COMPARE, m_count + 32'd20);
        send_mtc0(`CP0_STATUS, 32'h0000_8001);  // ie and im7
        send_mfc0(`CP0_COMPARE, 3'd0, 5'd11);
        send_mfc0(`CP0_COUNT, 3'd0, 5'd12);
        idle(1);
        wait_int(1'b1);
        send_mfc0(`CP0_CAUSE, 3'd0, 5'd8);
        send_mtc0(`CP0_COMPARE, m_count + 32'd4000);
        idle(1);
        wait_int(1'b0);

        send_mtc0(`CP0_STATUS, 32'h0000_3c01);
        ext_int <= 6'b000101;
        idle(1);
        wait_int(1'b1);
        send_mfc0(`CP0_CAUSE, 3'd0, 5'd9);
        send_mtc0(`CP0_STATUS, 32'h0000_4001);  // only ip6 enabled
        idle(1);
        wait_int(1'b0);
        ext_int <= 6'b010000;
        wait_int(1'b1);
        send_exc(exc_int, 1'b0, 32'd0);
        send_alu(1'b1, 5'd10, $random(seed));   // dropped by the flush
        idle(1);
        send_mfc0(`CP0_CAUSE, 3'd0, 5'd9);
        send_eret();
        idle(1);
        ext_int <= 6'b000000;
        send_mtc0(`CP0_STATUS, 32'd0);
        idle(3);

        if (wb_stage_inst.wb_stage_chk_inst.assert_fails == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("%0d assertion failures", wb_stage_inst.wb_stage_chk_inst.assert_fails);
            $display("TEST FAILED");
            $fatal(1, "assertions failed");
        end
    end

endmodule

//--- filelist.f
+incdir+include
source/wb_pkg.sv
source/ws_latch.sv
source/cp0_regs.sv
source/cp0_timer.sv
source/wb_commit.sv
source/wb_stage.sv
sim/wb_stage_chk.sv
sim/wb_stage_tb.sv

//--- Bender.yml
package:
  name: wb_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/wb_pkg.sv
      - source/ws_latch.sv
      - source/cp0_regs.sv
      - source/cp0_timer.sv
      - source/wb_commit.sv
      - source/wb_stage.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/wb_stage_chk.sv
      - sim/wb_stage_tb.sv
